//--- common/burst_consts.svh
`ifndef BURST_CONSTS_SVH
`define BURST_CONSTS_SVH

// slot pool and burst shape
`define BURST_SLOTS 4
`define BURST_LEN   16

// field widths
`define DATA_W  16
`define INDEX_W 4
`define ROW_W   16
`define COL_W   10
`define CA_W    14
`define DM_W    2  // one bit per byte lane

// cycles from the phase-two command cycle to data beat 0
`define RD_TO_DATA 12
`define WR_TO_DATA 10

`endif

//--- common/burst_pkg.sv
`include "burst_consts.svh"

package burst_pkg;

	typedef logic [1:0]              bg_t;
	typedef logic [1:0]              bank_t;
	typedef logic [`ROW_W-1:0]       row_t;
	typedef logic [`COL_W-1:0]       col_t;
	typedef logic [`COL_W-5:0]       col_block_t;  // column bits above the beat
	typedef logic [3:0]              beat_t;
	typedef logic [`DATA_W-1:0]      data_t;
	typedef logic [`INDEX_W-1:0]     index_t;
	typedef logic [1:0]              slot_id_t;
	typedef logic [`CA_W-1:0]        ca_t;
	typedef logic [`BURST_LEN-1:0]   mask_t;
	typedef logic [4:0]              beat_cnt_t;   // 0 to 16 beats moved

	typedef enum logic [2:0] {
		slot_empty,
		slot_filling,
		slot_full,
		slot_waiting,
		slot_returning
	} slot_state_t;

	typedef enum logic {
		kind_read,
		kind_write
	} req_kind_t;

	typedef enum logic [2:0] {
		cmd_none,
		cmd_activate,
		cmd_read,
		cmd_write,
		cmd_precharge
	} cmd_t;

endpackage

//--- burst_slot/burst_slot.sv
`timescale 1ns/1ps
`include "burst_consts.svh"

module burst_slot (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   load_new,
	input  logic                   load_beat,
	input  logic                   close_open,
	input  burst_pkg::req_kind_t   arb_kind,
	input  burst_pkg::bg_t         arb_bg,
	input  burst_pkg::bank_t       arb_bank,
	input  burst_pkg::row_t        arb_row,
	input  burst_pkg::col_t        arb_col,
	input  burst_pkg::data_t       arb_data,
	input  burst_pkg::index_t      arb_index,
	input  logic                   issue,
	input  logic                   xfer_start,
	input  logic                   rd_capture,
	input  burst_pkg::beat_t       capture_beat,
	input  burst_pkg::data_t       dq_in,
	input  burst_pkg::mask_t       clear_beat,
	input  burst_pkg::beat_t       beat_sel,
	output burst_pkg::slot_state_t state,
	output burst_pkg::req_kind_t   kind,
	output burst_pkg::bg_t         bg,
	output burst_pkg::bank_t       bank,
	output burst_pkg::row_t        row,
	output burst_pkg::col_block_t  col_block,
	output burst_pkg::mask_t       mask,
	output logic                   match,
	output burst_pkg::data_t       beat_data,
	output burst_pkg::index_t      ret_index,
	output burst_pkg::data_t       xfer_data
);
	import burst_pkg::*;

	data_t  data  [`BURST_LEN];
	index_t index [`BURST_LEN];
	beat_t  arb_beat;

	assign arb_beat = arb_col[3:0];

	// same kind and same 16-word column block of one open row
	assign match = (state == slot_filling) && (kind == arb_kind) && (bg == arb_bg) &&
		(bank == arb_bank) && (row == arb_row) && (col_block == arb_col[`COL_W-1:4]);

	assign beat_data = data[beat_sel];
	assign ret_index = index[beat_sel];
	assign xfer_data = data[capture_beat];  // write beat going out on dq

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= slot_empty;
			mask  <= '0;
		end else begin
			case (state)
				slot_empty:     if (load_new) state <= slot_filling;
				slot_filling:   if (close_open) state <= slot_full;
				slot_full:      if (issue) state <= slot_waiting;
				slot_waiting:   if (xfer_start) state <= slot_returning;
				slot_returning: if (close_open) state <= slot_empty;  // drained
				default:        state <= slot_empty;
			endcase

			if (load_new)
				mask <= mask_t'(1) << arb_beat;
			else if (load_beat)
				mask <= mask | (mask_t'(1) << arb_beat);
			else
				mask <= mask & ~clear_beat;
		end
	end

	// burst address, taken from the first request
	always_ff @(posedge clk) begin
		if (load_new) begin
			kind      <= arb_kind;
			bg        <= arb_bg;
			bank      <= arb_bank;
			row       <= arb_row;
			col_block <= arb_col[`COL_W-1:4];
		end
	end

	always_ff @(posedge clk) begin
		if (load_beat) begin
			data[arb_beat]  <= arb_data;
			index[arb_beat] <= arb_index;
		end else if (rd_capture && mask[capture_beat]) begin
			data[capture_beat] <= dq_in;  // only requested beats
		end
	end

endmodule

//--- source/burst_collector.sv
`timescale 1ns/1ps
`include "burst_consts.svh"

module burst_collector (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          arb_valid,
	input  burst_pkg::slot_state_t        slot_state [`BURST_SLOTS],
	input  logic [`BURST_SLOTS-1:0]       slot_match,
	output logic                          accept_ok,
	output logic [`BURST_SLOTS-1:0]       load_new,
	output logic [`BURST_SLOTS-1:0]       load_beat,
	output logic [`BURST_SLOTS-1:0]       close_open,
	output burst_pkg::slot_id_t           open_slot
);
	import burst_pkg::*;

	logic [2:0] empty_cnt;
	logic       any_empty;
	slot_id_t   first_empty;
	logic       join_open;

	always_comb begin
		empty_cnt   = '0;
		any_empty   = 1'b0;
		first_empty = '0;
		// walk down so the lowest empty slot wins
		for (int i = `BURST_SLOTS - 1; i >= 0; i--) begin
			if (slot_state[i] == slot_empty) begin
				empty_cnt   = empty_cnt + 3'd1;
				any_empty   = 1'b1;
				first_empty = slot_id_t'(i);
			end
		end
	end

	assign join_open = arb_valid && slot_match[open_slot];

	always_comb begin
		load_new   = '0;
		load_beat  = '0;
		close_open = '0;
		if (join_open) begin
			load_beat[open_slot] = 1'b1;
		end else begin
			if (slot_state[open_slot] == slot_filling)
				close_open[open_slot] = 1'b1;  // idle cycle or mismatch ends the burst
			if (arb_valid && any_empty) begin
				load_new[first_empty]  = 1'b1;
				load_beat[first_empty] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			open_slot <= '0;
			accept_ok <= 1'b1;
		end else begin
			if (arb_valid && !join_open && any_empty)
				open_slot <= first_empty;
			// keep one slot spare unless the arbiter is quiet
			accept_ok <= (empty_cnt > 3'd1) || (empty_cnt == 3'd1 && !arb_valid);
		end
	end

endmodule

//--- source/ddr5_cmd_encoder.sv
`timescale 1ns/1ps
`include "burst_consts.svh"

module ddr5_cmd_encoder (
	input  logic                     clk,
	input  logic                     rst_n,
	input  burst_pkg::cmd_t          cmd,
	input  burst_pkg::slot_id_t      cmd_slot,
	input  burst_pkg::bg_t           bg,
	input  burst_pkg::bank_t         bank,
	input  burst_pkg::row_t          row,
	input  burst_pkg::col_block_t    col_block,
	input  burst_pkg::mask_t         mask,
	output logic                     cs_n,
	output burst_pkg::ca_t           ca,
	output logic [`BURST_SLOTS-1:0]  issue,
	output logic                     xfer_start,
	output burst_pkg::req_kind_t     xfer_kind,
	output burst_pkg::slot_id_t      xfer_slot
);
	import burst_pkg::*;

	cmd_t       cmd_q;
	slot_id_t   slot_q;
	row_t       row_q;
	col_block_t col_block_q;
	logic       full_q;       // all 16 beats written
	logic       p1_pending;
	logic       phase_two;
	logic       rw_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cs_n       <= 1'b1;
			ca         <= '0;
			cmd_q      <= cmd_none;
			slot_q     <= '0;
			p1_pending <= 1'b0;
			phase_two  <= 1'b0;
		end else begin
			cs_n       <= 1'b1;
			ca         <= '0;
			phase_two  <= p1_pending;
			p1_pending <= 1'b0;
			if (cmd != cmd_none) begin
				cmd_q      <= cmd;
				slot_q     <= cmd_slot;
				p1_pending <= 1'b1;
				cs_n       <= 1'b0;
				case (cmd)
					cmd_activate:  ca <= {4'b0000, bg, bank, row[3:0], 2'b00};
					cmd_read:      ca <= {4'b0000, bg, bank, 1'b1, 5'b11101};
					cmd_write:     ca <= {4'b0000, bg, bank, 1'b1, 5'b01101};
					cmd_precharge: ca <= {4'b0000, bg, bank, 6'b011011};
					default:       ca <= '0;
				endcase
			end else if (p1_pending) begin
				case (cmd_q)  // second half, cs_n back high
					cmd_activate: ca <= {2'b00, row_q[`ROW_W-1:4]};
					cmd_read:     ca <= {3'b000, 1'b1, 2'b00, col_block_q, 2'b00};
					cmd_write:    ca <= {2'b00, full_q, 1'b1, 2'b00, col_block_q, 2'b00};
					default:      ca <= '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd != cmd_none) begin
			row_q       <= row;
			col_block_q <= col_block;
			full_q      <= &mask;
		end
	end

	assign rw_q       = (cmd_q == cmd_read) || (cmd_q == cmd_write);
	assign xfer_start = phase_two && rw_q;
	assign xfer_kind  = (cmd_q == cmd_write) ? kind_write : kind_read;
	assign xfer_slot  = slot_q;
	assign issue      = xfer_start ? (`BURST_SLOTS'(1) << slot_q) : '0;

endmodule

//--- source/dq_sequencer.sv
`timescale 1ns/1ps
`include "burst_consts.svh"

module dq_sequencer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     xfer_start,
	input  burst_pkg::req_kind_t     xfer_kind,
	input  burst_pkg::slot_id_t      cmd_slot,
	input  burst_pkg::mask_t         slot_mask [`BURST_SLOTS],
	input  burst_pkg::data_t         slot_data [`BURST_SLOTS],
	output burst_pkg::data_t         dq_out,
	output logic                     dq_oe,
	output logic [`DM_W-1:0]         dm_n,
	output logic [`BURST_SLOTS-1:0]  rd_capture,
	output burst_pkg::beat_t         capture_beat,
	output logic [`BURST_SLOTS-1:0]  returning_go,
	output burst_pkg::beat_cnt_t     beats_done [`BURST_SLOTS]
);
	import burst_pkg::*;

	logic       active;
	req_kind_t  kind_q;
	slot_id_t   slot_q;
	logic [4:0] cnt;      // cycles since the phase-two cycle
	logic [4:0] lead;
	logic [4:0] offset;
	logic       in_window;

	// a write beat is registered one cycle ahead of its bus cycle
	assign lead      = (kind_q == kind_write) ? 5'(`WR_TO_DATA - 1) : 5'(`RD_TO_DATA);
	assign offset    = cnt - lead;
	assign in_window = active && (cnt >= lead) && (offset < 5'(`BURST_LEN));
	assign capture_beat = offset[3:0];

	assign rd_capture   = (in_window && kind_q == kind_read) ? (`BURST_SLOTS'(1) << slot_q) : '0;
	assign returning_go = (in_window && offset == 5'd0) ? (`BURST_SLOTS'(1) << slot_q) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			kind_q <= kind_read;
			slot_q <= '0;
			cnt    <= '0;
			dq_out <= '0;
			dq_oe  <= 1'b0;
			dm_n   <= '1;
			for (int i = 0; i < `BURST_SLOTS; i++)
				beats_done[i] <= '0;
		end else begin
			dq_oe <= 1'b0;
			dm_n  <= '1;
			if (xfer_start) begin
				active <= 1'b1;
				kind_q <= xfer_kind;
				slot_q <= cmd_slot;
				cnt    <= 5'd1;
				beats_done[cmd_slot] <= '0;
			end else if (active) begin
				cnt <= cnt + 5'd1;
				if (in_window) begin
					beats_done[slot_q] <= beats_done[slot_q] + 5'd1;
					if (kind_q == kind_write) begin
						dq_out <= slot_data[slot_q];
						dq_oe  <= 1'b1;
						dm_n   <= {`DM_W{~slot_mask[slot_q][capture_beat]}};
					end
					if (capture_beat == 4'd15)
						active <= 1'b0;  // last beat
				end
			end
		end
	end

endmodule

//--- source/burst_returner.sv
`timescale 1ns/1ps
`include "burst_consts.svh"

module burst_returner (
	input  logic                     clk,
	input  logic                     rst_n,
	input  burst_pkg::slot_state_t   slot_state [`BURST_SLOTS],
	input  burst_pkg::mask_t         slot_mask [`BURST_SLOTS],
	input  burst_pkg::beat_cnt_t     beats_done [`BURST_SLOTS],
	input  burst_pkg::req_kind_t     served_kind,
	input  burst_pkg::data_t         beat_data,
	input  burst_pkg::index_t        beat_index,
	output burst_pkg::slot_id_t      served_slot,
	output burst_pkg::beat_t         beat_sel,
	output burst_pkg::mask_t         clear_beat [`BURST_SLOTS],
	output logic [`BURST_SLOTS-1:0]  done_slot,
	output logic                     ret_valid,
	output burst_pkg::req_kind_t     ret_kind,
	output burst_pkg::data_t         ret_data,
	output burst_pkg::index_t        ret_index
);
	import burst_pkg::*;

	slot_id_t cur_slot;
	logic     found;
	logic     emit;

	always_comb begin
		found       = 1'b0;
		served_slot = cur_slot;
		if (slot_state[cur_slot] == slot_returning && slot_mask[cur_slot] != '0) begin
			found = 1'b1;  // finish the slot in hand first
		end else begin
			for (int i = `BURST_SLOTS - 1; i >= 0; i--) begin
				if (slot_state[i] == slot_returning && slot_mask[i] != '0) begin
					found       = 1'b1;
					served_slot = slot_id_t'(i);
				end
			end
		end
	end

	// lowest outstanding column first
	always_comb begin
		beat_sel = '0;
		for (int b = `BURST_LEN - 1; b >= 0; b--)
			if (slot_mask[served_slot][b])
				beat_sel = beat_t'(b);
	end

	assign emit = found && (beats_done[served_slot] > {1'b0, beat_sel});

	always_comb begin
		for (int i = 0; i < `BURST_SLOTS; i++) begin
			clear_beat[i] = (emit && served_slot == slot_id_t'(i)) ?
				(mask_t'(1) << beat_sel) : '0;
			done_slot[i] = (slot_state[i] == slot_returning) && (slot_mask[i] == '0);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cur_slot  <= '0;
			ret_valid <= 1'b0;
		end else begin
			if (found)
				cur_slot <= served_slot;
			ret_valid <= emit;
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			ret_kind  <= served_kind;
			ret_data  <= beat_data;
			ret_index <= beat_index;
		end
	end

endmodule

//--- source/burst_handler.sv
`timescale 1ns/1ps
`include "burst_consts.svh"

module burst_handler (
	input  logic                    clk,
	input  logic                    rst_n,
	// bank arbiter
	input  logic                    arb_valid,
	input  burst_pkg::req_kind_t    arb_kind,
	input  burst_pkg::bg_t          arb_bg,
	input  burst_pkg::bank_t        arb_bank,
	input  burst_pkg::row_t         arb_row,
	input  burst_pkg::col_t         arb_col,
	input  burst_pkg::data_t        arb_data,
	input  burst_pkg::index_t       arb_index,
	output logic                    accept_ok,
	// timing controller
	output burst_pkg::slot_state_t  slot_state [`BURST_SLOTS],
	output burst_pkg::req_kind_t    slot_kind [`BURST_SLOTS],
	output burst_pkg::bg_t          slot_bg [`BURST_SLOTS],
	output burst_pkg::bank_t        slot_bank [`BURST_SLOTS],
	output burst_pkg::row_t         slot_row [`BURST_SLOTS],
	input  burst_pkg::cmd_t         cmd,
	input  burst_pkg::slot_id_t     cmd_slot,
	// DDR5 pins with dq split for the pad ring
	output logic                    cs_n,
	output burst_pkg::ca_t          ca,
	output burst_pkg::data_t        dq_out,
	output logic                    dq_oe,
	output logic [`DM_W-1:0]        dm_n,
	input  burst_pkg::data_t        dq_in,
	// returner
	output logic                    ret_valid,
	output burst_pkg::req_kind_t    ret_kind,
	output burst_pkg::data_t        ret_data,
	output burst_pkg::index_t       ret_index
);
	import burst_pkg::*;

	logic [`BURST_SLOTS-1:0] load_new, load_beat, close_open;
	logic [`BURST_SLOTS-1:0] slot_match, issue, rd_capture, returning_go, done_slot;
	slot_id_t   xfer_slot, served_slot;
	col_block_t slot_col_block [`BURST_SLOTS];
	mask_t      slot_mask [`BURST_SLOTS];
	mask_t      clear_beat [`BURST_SLOTS];
	data_t      slot_beat_data [`BURST_SLOTS];
	data_t      slot_xfer_data [`BURST_SLOTS];
	index_t     slot_ret_index [`BURST_SLOTS];
	beat_cnt_t  beats_done [`BURST_SLOTS];
	beat_t      capture_beat, beat_sel;
	logic       xfer_start;
	req_kind_t  xfer_kind;

	burst_collector u_collector (
		.clk        (clk),
		.rst_n      (rst_n),
		.arb_valid  (arb_valid),
		.slot_state (slot_state),
		.slot_match (slot_match),
		.accept_ok  (accept_ok),
		.load_new   (load_new),
		.load_beat  (load_beat),
		.close_open (close_open),
		.open_slot  ()
	);

	for (genvar g = 0; g < `BURST_SLOTS; g++) begin : g_slot
		burst_slot u_slot (
			.clk          (clk),
			.rst_n        (rst_n),
			.load_new     (load_new[g]),
			.load_beat    (load_beat[g]),
			.close_open   (close_open[g] | done_slot[g]),  // fill ends or drain ends
			.arb_kind     (arb_kind),
			.arb_bg       (arb_bg),
			.arb_bank     (arb_bank),
			.arb_row      (arb_row),
			.arb_col      (arb_col),
			.arb_data     (arb_data),
			.arb_index    (arb_index),
			.issue        (issue[g]),
			.xfer_start   (returning_go[g]),
			.rd_capture   (rd_capture[g]),
			.capture_beat (capture_beat),
			.dq_in        (dq_in),
			.clear_beat   (clear_beat[g]),
			.beat_sel     (beat_sel),
			.state        (slot_state[g]),
			.kind         (slot_kind[g]),
			.bg           (slot_bg[g]),
			.bank         (slot_bank[g]),
			.row          (slot_row[g]),
			.col_block    (slot_col_block[g]),
			.mask         (slot_mask[g]),
			.match        (slot_match[g]),
			.beat_data    (slot_beat_data[g]),
			.ret_index    (slot_ret_index[g]),
			.xfer_data    (slot_xfer_data[g])
		);
	end

	ddr5_cmd_encoder u_encoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.cmd_slot   (cmd_slot),
		.bg         (slot_bg[cmd_slot]),
		.bank       (slot_bank[cmd_slot]),
		.row        (slot_row[cmd_slot]),
		.col_block  (slot_col_block[cmd_slot]),
		.mask       (slot_mask[cmd_slot]),
		.cs_n       (cs_n),
		.ca         (ca),
		.issue      (issue),
		.xfer_start (xfer_start),
		.xfer_kind  (xfer_kind),
		.xfer_slot  (xfer_slot)
	);

	dq_sequencer u_sequencer (
		.clk          (clk),
		.rst_n        (rst_n),
		.xfer_start   (xfer_start),
		.xfer_kind    (xfer_kind),
		.cmd_slot     (xfer_slot),
		.slot_mask    (slot_mask),
		.slot_data    (slot_xfer_data),
		.dq_out       (dq_out),
		.dq_oe        (dq_oe),
		.dm_n         (dm_n),
		.rd_capture   (rd_capture),
		.capture_beat (capture_beat),
		.returning_go (returning_go),
		.beats_done   (beats_done)
	);

	burst_returner u_returner (
		.clk         (clk),
		.rst_n       (rst_n),
		.slot_state  (slot_state),
		.slot_mask   (slot_mask),
		.beats_done  (beats_done),
		.served_kind (slot_kind[served_slot]),
		.beat_data   (slot_beat_data[served_slot]),
		.beat_index  (slot_ret_index[served_slot]),
		.served_slot (served_slot),
		.beat_sel    (beat_sel),
		.clear_beat  (clear_beat),
		.done_slot   (done_slot),
		.ret_valid   (ret_valid),
		.ret_kind    (ret_kind),
		.ret_data    (ret_data),
		.ret_index   (ret_index)
	);

endmodule

//--- tb/burst_handler_tb.sv
`timescale 1ns/1ps
`include "burst_consts.svh"

module burst_handler_tb;
	import burst_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        arb_valid;
	req_kind_t   arb_kind;
	bg_t         arb_bg;
	bank_t       arb_bank;
	row_t        arb_row;
	col_t        arb_col;
	data_t       arb_data;
	index_t      arb_index;
	logic        accept_ok;
	slot_state_t slot_state [`BURST_SLOTS];
	req_kind_t   slot_kind [`BURST_SLOTS];
	bg_t         slot_bg [`BURST_SLOTS];
	bank_t       slot_bank [`BURST_SLOTS];
	row_t        slot_row [`BURST_SLOTS];
	cmd_t        cmd;
	slot_id_t    cmd_slot;
	logic        cs_n;
	ca_t         ca;
	data_t       dq_out;
	logic        dq_oe;
	logic [`DM_W-1:0] dm_n;
	data_t       dq_in;
	logic        ret_valid;
	req_kind_t   ret_kind;
	data_t       ret_data;
	index_t      ret_index;

	// request table with one entry per arbiter word
	req_kind_t rq_kind [6];
	bg_t       rq_bg [6];
	bank_t     rq_bank [6];
	row_t      rq_row [6];
	col_t      rq_col [6];
	data_t     rq_data [6];
	index_t    rq_index [6];
	slot_id_t  rq_slot [6];  // slot the word should land in

	// command table with expected CA words
	cmd_t     cm_cmd [5];
	slot_id_t cm_slot [5];
	ca_t      cm_ca1 [5];
	ca_t      cm_ca2 [5];

	integer    errors;
	integer    seed;
	logic      timed_out;
	data_t     rd_beat [`BURST_LEN];
	index_t    got_index [$];
	req_kind_t got_kind [$];
	data_t     got_data [$];

	burst_handler uut (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// collect every returned word
	always @(negedge clk) begin
		if (rst_n && ret_valid) begin
			got_index.push_back(ret_index);
			got_kind.push_back(ret_kind);
			got_data.push_back(ret_data);
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp_v, act_v);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	task automatic fail_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("timed out while waiting for %s", what);
	endtask

	task automatic load_tables();
		// three writes in one block, one write in another row, two reads
		rq_kind = '{kind_write, kind_write, kind_write, kind_write, kind_read, kind_read};
		rq_bg   = '{2'd1, 2'd1, 2'd1, 2'd1, 2'd2, 2'd2};
		rq_bank = '{2'd2, 2'd2, 2'd2, 2'd2, 2'd3, 2'd3};
		rq_row  = '{16'h1234, 16'h1234, 16'h1234, 16'h5678, 16'h0abc, 16'h0abc};
		rq_col  = '{10'h045, 10'h043, 10'h04a, 10'h101, 10'h2f7, 10'h2f2};
		rq_data = '{16'ha5a5, 16'h0f0f, 16'h1357, 16'hbeef, 16'h0000, 16'h0000};
		rq_index = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6};
		rq_slot = '{2'd0, 2'd0, 2'd0, 2'd1, 2'd2, 2'd2};

		cm_cmd  = '{cmd_activate, cmd_write, cmd_activate, cmd_read, cmd_precharge};
		cm_slot = '{2'd0, 2'd0, 2'd2, 2'd2, 2'd1};
		cm_ca1[0] = {4'b0000, 2'd1, 2'd2, 4'h4, 2'b00};
		cm_ca2[0] = {2'b00, 12'h123};
		cm_ca1[1] = {4'b0000, 2'd1, 2'd2, 1'b1, 5'b01101};
		cm_ca2[1] = {2'b00, 1'b0, 1'b1, 2'b00, 6'h04, 2'b00};  // partial mask
		cm_ca1[2] = {4'b0000, 2'd2, 2'd3, 4'hc, 2'b00};
		cm_ca2[2] = {2'b00, 12'h0ab};
		cm_ca1[3] = {4'b0000, 2'd2, 2'd3, 1'b1, 5'b11101};
		cm_ca2[3] = {3'b000, 1'b1, 2'b00, 6'h2f, 2'b00};
		cm_ca1[4] = {4'b0000, 2'd1, 2'd2, 6'b011011};
		cm_ca2[4] = '0;
	endtask

	// both CA phases, ending at the negedge of the phase-two cycle
	task automatic issue_cmd(input integer c);
		integer n;
		@(posedge clk);
		#1;
		cmd      = cm_cmd[c];
		cmd_slot = cm_slot[c];
		@(posedge clk);
		#1;
		cmd = cmd_none;
		n = 0;
		@(negedge clk);
		while (cs_n !== 1'b0 && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (cs_n !== 1'b0) begin
			fail_timeout("phase one on cs_n");
		end else begin
			check_val($sformatf("cmd %0d phase one ca", c), cm_ca1[c], ca);
			@(negedge clk);
			check_val($sformatf("cmd %0d phase two cs_n", c), 1'b1, cs_n);
			check_val($sformatf("cmd %0d phase two ca", c), cm_ca2[c], ca);
		end
	endtask

	// cycle k counts from the phase-two cycle
	task automatic data_window(input integer c);
		logic  wr;
		mask_t m;
		data_t d [`BURST_LEN];
		integer b;
		wr = (cm_cmd[c] == cmd_write);
		m  = '0;
		for (int r = 0; r < 6; r++) begin
			if (rq_slot[r] == cm_slot[c]) begin
				m[rq_col[r][3:0]] = 1'b1;
				d[rq_col[r][3:0]] = rq_data[r];
			end
		end
		for (int k = 1; k <= 30; k++) begin
			@(posedge clk);
			#1;
			dq_in = data_t'($random(seed));
			if (k >= `RD_TO_DATA && k < `RD_TO_DATA + `BURST_LEN)
				rd_beat[k - `RD_TO_DATA] = dq_in;
			@(negedge clk);
			b = k - `WR_TO_DATA;
			if (wr && b >= 0 && b < `BURST_LEN) begin
				check_val($sformatf("write beat %0d dq_oe", b), 1'b1, dq_oe);
				check_val($sformatf("write beat %0d dm_n", b), {2{~m[b]}}, dm_n);
				if (m[b])
					check_val($sformatf("write beat %0d dq_out", b), d[b], dq_out);
			end else begin
				check_val($sformatf("cycle %0d dq_oe", k), 1'b0, dq_oe);
				check_val($sformatf("cycle %0d dm_n", k), 2'b11, dm_n);
			end
		end
	endtask

	task automatic check_returns(input integer c);
		integer cnt;
		integer p;
		integer n;
		cnt = 0;
		for (int r = 0; r < 6; r++)
			if (rq_slot[r] == cm_slot[c])
				cnt++;
		n = 0;
		while (got_index.size() < cnt && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (got_index.size() < cnt) begin
			fail_timeout("returned words");
		end else begin
			p = 0;
			for (int b = 0; b < `BURST_LEN; b++) begin
				for (int r = 0; r < 6; r++) begin
					if (rq_slot[r] == cm_slot[c] && rq_col[r][3:0] == b) begin
						check_val($sformatf("return %0d index", p), rq_index[r],
							got_index[p]);
						check_val($sformatf("return %0d kind", p), rq_kind[r], got_kind[p]);
						if (rq_kind[r] == kind_read)
							check_val($sformatf("return %0d data", p), rd_beat[b],
								got_data[p]);
						p++;
					end
				end
			end
			n = 0;
			while (slot_state[cm_slot[c]] != slot_empty && n < 50) begin
				@(negedge clk);
				n++;
			end
			if (slot_state[cm_slot[c]] != slot_empty) begin
				fail_timeout("drained slot to empty");
			end else begin
				check_val("return count", cnt, got_index.size());
				check_val("accept_ok after drain", 1'b1, accept_ok);
			end
		end
	endtask

	initial begin
		errors    = 0;
		seed      = 32'h871e_e7a9;
		timed_out = 1'b0;
		rst_n     = 1'b0;
		arb_valid = 1'b0;
		arb_kind  = kind_read;
		arb_bg    = '0;
		arb_bank  = '0;
		arb_row   = '0;
		arb_col   = '0;
		arb_data  = '0;
		arb_index = '0;
		cmd       = cmd_none;
		cmd_slot  = '0;
		dq_in     = '0;
		load_tables();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_val("reset cs_n", 1'b1, cs_n);
		check_val("reset ca", '0, ca);
		check_val("reset dq_oe", 1'b0, dq_oe);
		check_val("reset dm_n", 2'b11, dm_n);
		check_val("reset ret_valid", 1'b0, ret_valid);
		check_val("reset accept_ok", 1'b1, accept_ok);
		for (int s = 0; s < `BURST_SLOTS; s++)
			check_val($sformatf("reset slot %0d", s), slot_empty, slot_state[s]);

		for (int r = 0; r < 6; r++) begin
			@(posedge clk);
			#1;
			check_val($sformatf("accept_ok before req %0d", r), 1'b1, accept_ok);
			arb_valid = 1'b1;
			arb_kind  = rq_kind[r];
			arb_bg    = rq_bg[r];
			arb_bank  = rq_bank[r];
			arb_row   = rq_row[r];
			arb_col   = rq_col[r];
			arb_data  = rq_data[r];
			arb_index = rq_index[r];
		end
		@(posedge clk);
		#1;
		arb_valid = 1'b0;
		@(negedge clk);
		// last spare slot taken with the arbiter busy
		check_val("throttle accept_ok", 1'b0, accept_ok);
		check_val("slot 0 state", slot_full, slot_state[0]);
		check_val("slot 1 state", slot_full, slot_state[1]);
		check_val("slot 2 state", slot_filling, slot_state[2]);
		@(negedge clk);
		check_val("slot 2 closed", slot_full, slot_state[2]);
		check_val("slot 3 state", slot_empty, slot_state[3]);
		for (int r = 0; r < 6; r++) begin
			check_val($sformatf("req %0d slot row", r), rq_row[r], slot_row[rq_slot[r]]);
			check_val($sformatf("req %0d slot kind", r), rq_kind[r], slot_kind[rq_slot[r]]);
			check_val($sformatf("req %0d slot bg", r), rq_bg[r], slot_bg[rq_slot[r]]);
			check_val($sformatf("req %0d slot bank", r), rq_bank[r], slot_bank[rq_slot[r]]);
		end

		for (int c = 0; c < 5 && !timed_out; c++) begin
			got_index.delete();
			got_kind.delete();
			got_data.delete();
			issue_cmd(c);
			if (!timed_out && (cm_cmd[c] == cmd_write || cm_cmd[c] == cmd_read)) begin
				data_window(c);
				check_returns(c);
			end
		end
		@(negedge clk);
		check_val("slot 1 left full", slot_full, slot_state[1]);
		check_val("final accept_ok", 1'b1, accept_ok);
		finish_run();
	end

endmodule

//--- tb/burst_handler_assert.sv
`timescale 1ns/1ps
`include "burst_consts.svh"

module burst_handler_assert (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   cs_n,
	input logic                   dq_oe,
	input logic                   ret_valid,
	input burst_pkg::req_kind_t   xfer_kind,
	input burst_pkg::slot_state_t slot_state [`BURST_SLOTS]
);
	import burst_pkg::*;

	logic all_empty;

	always_comb begin
		all_empty = 1'b1;
		for (int i = 0; i < `BURST_SLOTS; i++)
			if (slot_state[i] != slot_empty)
				all_empty = 1'b0;
	end

	// commands are two cycles with cs_n low only in the first
	cs_single: assert property (@(posedge clk) disable iff (!rst_n) !cs_n |=> cs_n)
		else $error("cs_n low on two cycles in a row");

	oe_write: assert property (@(posedge clk) disable iff (!rst_n)
		dq_oe |-> xfer_kind == kind_write)
		else $error("dq_oe high outside a write transfer");

	ret_busy: assert property (@(posedge clk) disable iff (!rst_n) ret_valid |-> !all_empty)
		else $error("ret_valid high with every slot empty");

endmodule

bind burst_handler burst_handler_assert u_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.cs_n       (cs_n),
	.dq_oe      (dq_oe),
	.ret_valid  (ret_valid),
	.xfer_kind  (xfer_kind),
	.slot_state (slot_state)
);

//--- burst_handler.f
+incdir+common
common/burst_pkg.sv
burst_slot/burst_slot.sv
source/burst_collector.sv
source/ddr5_cmd_encoder.sv
source/dq_sequencer.sv
source/burst_returner.sv
source/burst_handler.sv
tb/burst_handler_tb.sv
tb/burst_handler_assert.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run, pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f burst_handler.f \
	--top-module burst_handler_tb -o burst_handler_sim &&
./obj_dir/burst_handler_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
exit 0 ||
exit 1
